/* Makefile */
# Verilator build and run of the TCDM subsystem testbench

VERILATOR ?= verilator
TOP       := tcdm_subsystem_tb
FILELIST  := tcdm_subsystem_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := Test completed successfully

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(FILELIST) $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/hwce_tcdm_xbar.sv */
/*
  Point-to-point crossbar, lane k of a group always hits bank k
  Bank-group conflicts resolved by fixed priority, loser is not granted
  One response in flight per master group
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module hwce_tcdm_xbar import tcdm_pkg::*; (
    input  logic                                        clk,
    input  logic                                        rst_n,
    // Master groups
    input  logic  [`TCDM_N_GRP-1:0]                     grp_req_i,
    input  addr_t [`TCDM_N_GRP-1:0]                     grp_add_i,
    input  logic  [`TCDM_N_GRP-1:0]                     grp_wen_i,   // 1 = load
    input  data_t [`TCDM_N_GRP-1:0][`TCDM_GRP_SIZE-1:0] grp_wdata_i,
    input  be_t   [`TCDM_N_GRP-1:0][`TCDM_GRP_SIZE-1:0] grp_be_i,
    output logic  [`TCDM_N_GRP-1:0]                     grp_gnt_o,
    output logic  [`TCDM_N_GRP-1:0]                     grp_r_valid_o,
    output data_t [`TCDM_N_GRP-1:0][`TCDM_GRP_SIZE-1:0] grp_rdata_o,
    // Banks
    output logic  [`TCDM_N_LANES-1:0]                   bank_req_o,
    output row_t  [`TCDM_N_LANES-1:0]                   bank_row_o,
    output logic  [`TCDM_N_LANES-1:0]                   bank_wen_o,
    output data_t [`TCDM_N_LANES-1:0]                   bank_wdata_o,
    output be_t   [`TCDM_N_LANES-1:0]                   bank_be_o,
    input  data_t [`TCDM_N_LANES-1:0]                   bank_rdata_i
);

    gidx_t [`TCDM_N_GRP-1:0]  sel;     // Per bank group, chosen master
    logic  [`TCDM_N_GRP-1:0]  en;      // Per bank group, busy this cycle
    gsel_t [`TCDM_N_GRP-1:0]  tgt;     // Per master group, addressed bank group
    gsel_t [`TCDM_N_GRP-1:0]  tgt_q;   // Target of the access in flight
    logic  [`TCDM_N_GRP-1:0]  vld_q;   // Granted last cycle

    // Bank read data seen as bank groups of four words
    data_t [`TCDM_N_GRP-1:0][`TCDM_GRP_SIZE-1:0] bank_rdata_grp;

    assign bank_rdata_grp = bank_rdata_i;

    //////////////////////////////////////////////////
    // Request side, one mux per bank group
    //////////////////////////////////////////////////
    for (genvar b = 0; b < `TCDM_N_GRP; b++) begin : g_bank_grp

        tcdm_bank_sel #(
            .BANK_GRP  ( b         )
        ) i_bank_sel (
            .grp_req_i ( grp_req_i ),
            .grp_add_i ( grp_add_i ),
            .sel_o     ( sel[b]    ),
            .en_o      ( en[b]     )
        );

        for (genvar k = 0; k < `TCDM_GRP_SIZE; k++) begin : g_bank
            localparam int BI = b*`TCDM_GRP_SIZE + k;   // Flat bank index

            // Stores only touch banks with enabled bytes
            assign bank_req_o[BI]   = en[b] &&
                                      (grp_wen_i[sel[b]] || (|grp_be_i[sel[b]][k]));
            assign bank_row_o[BI]   = grp_add_i[sel[b]][`TCDM_ROW_LSB +: `TCDM_ROW_W];
            assign bank_wen_o[BI]   = grp_wen_i[sel[b]];
            assign bank_wdata_o[BI] = grp_wdata_i[sel[b]][k];
            assign bank_be_o[BI]    = grp_be_i[sel[b]][k];
        end
    end

    //////////////////////////////////////////////////
    // Grant and response side
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `TCDM_N_GRP; g++) begin : g_master_grp

        assign tgt[g] = grp_add_i[g][`TCDM_GSEL_LSB +: $bits(gsel_t)];

        // Granted only if our bank group picked us
        assign grp_gnt_o[g] = grp_req_i[g] && en[tgt[g]] &&
                              (sel[tgt[g]] == gidx_t'(g));

        always_ff @(posedge clk) begin
            if (grp_gnt_o[g]) tgt_q[g] <= tgt[g];   // Hold until next grant
        end

        assign grp_rdata_o[g] = bank_rdata_grp[tgt_q[g]];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) vld_q <= '0;
        else        vld_q <= grp_gnt_o;   // r_valid one cycle after grant
    end

    assign grp_r_valid_o = vld_q;

endmodule

/* design/tcdm_bank_array.sv */
/*
  Eight single-port banks, one cycle read latency
  Contents are random after power-up, no init
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_bank_array import tcdm_pkg::*; (
    input  logic                         clk,
    input  logic  [`TCDM_N_LANES-1:0]    bank_req_i,
    input  row_t  [`TCDM_N_LANES-1:0]    bank_row_i,
    input  logic  [`TCDM_N_LANES-1:0]    bank_wen_i,     // 1 = load
    input  data_t [`TCDM_N_LANES-1:0]    bank_wdata_i,
    input  be_t   [`TCDM_N_LANES-1:0]    bank_be_i,
    output data_t [`TCDM_N_LANES-1:0]    bank_rdata_o
);

    localparam int DEPTH = 1 << `TCDM_ROW_W;   // Words per bank

    //////////////////////////////////////////////////
    // One storage array per bank
    //////////////////////////////////////////////////
    for (genvar n = 0; n < `TCDM_N_LANES; n++) begin : g_bank

        data_t mem [DEPTH];
        data_t rdata_q;   // Read port register

        // Byte-masked store
        always_ff @(posedge clk) begin
            if (bank_req_i[n] && !bank_wen_i[n]) begin
                for (int b = 0; b < `TCDM_BE_W; b++) begin
                    if (bank_be_i[n][b]) begin
                        mem[bank_row_i[n]][8*b +: 8] <= bank_wdata_i[n][8*b +: 8];
                    end
                end
            end
        end

        // Load, sees the word before any same-edge write
        always_ff @(posedge clk) begin
            if (bank_req_i[n] && bank_wen_i[n]) begin
                rdata_q <= mem[bank_row_i[n]];
            end
        end

        assign bank_rdata_o[n] = rdata_q;   // Holds last load otherwise
    end

endmodule

/* design/tcdm_bank_sel.sv */
/*
  Master-group select for one bank group
  Fixed priority, lowest master group wins a conflict
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_bank_sel import tcdm_pkg::*; #(
    parameter int BANK_GRP = 0              // Bank group served here
) (
    input  logic  [`TCDM_N_GRP-1:0]  grp_req_i,
    input  addr_t [`TCDM_N_GRP-1:0]  grp_add_i,
    output gidx_t                    sel_o,   // Winning master group
    output logic                     en_o     // Some group targets us
);

    logic [`TCDM_N_GRP-1:0] hit;   // Per master group, targets this bank group

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    always_comb begin
        for (int g = 0; g < `TCDM_N_GRP; g++) begin
            // Only requesting groups count
            hit[g] = grp_req_i[g] &&
                     (grp_add_i[g][`TCDM_GSEL_LSB +: $bits(gsel_t)] == gsel_t'(BANK_GRP));
        end
    end

    //////////////////////////////////////////////////
    // Fixed priority pick
    //////////////////////////////////////////////////
    always_comb begin
        sel_o = '0;
        // Scan from the top, lowest hit overrides
        for (int g = `TCDM_N_GRP-1; g >= 0; g--) begin
            if (hit[g]) sel_o = gidx_t'(g);
        end
    end

    assign en_o = |hit;

endmodule

/* design/tcdm_lane_packer.sv */
/*
  Merges four lanes into one group access
  Requesting lanes must share row, bank group and load/store type
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_lane_packer import tcdm_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    // Engine lane side
    input  logic  [`TCDM_GRP_SIZE-1:0]      lane_req_i,
    input  addr_t [`TCDM_GRP_SIZE-1:0]      lane_add_i,
    input  logic  [`TCDM_GRP_SIZE-1:0]      lane_wen_i,    // 1 = load
    input  data_t [`TCDM_GRP_SIZE-1:0]      lane_wdata_i,
    input  be_t   [`TCDM_GRP_SIZE-1:0]      lane_be_i,
    output logic  [`TCDM_GRP_SIZE-1:0]      lane_gnt_o,
    output logic  [`TCDM_GRP_SIZE-1:0]      lane_r_valid_o,
    output data_t [`TCDM_GRP_SIZE-1:0]      lane_r_rdata_o,
    // Crossbar side
    output logic                            grp_req_o,
    output addr_t                           grp_add_o,
    output logic                            grp_wen_o,
    output data_t [`TCDM_GRP_SIZE-1:0]      grp_wdata_o,
    output be_t   [`TCDM_GRP_SIZE-1:0]      grp_be_o,
    input  logic                            grp_gnt_i,
    input  logic                            grp_r_valid_i,
    input  data_t [`TCDM_GRP_SIZE-1:0]      grp_rdata_i
);

    localparam int LIDX_W = $clog2(`TCDM_GRP_SIZE);

    logic [LIDX_W-1:0]         lead;      // Lowest requesting lane
    logic [`TCDM_GRP_SIZE-1:0] pend_q;    // Lanes waiting for r_valid

    //////////////////////////////////////////////////
    // Request merge
    //////////////////////////////////////////////////
    always_comb begin
        lead = '0;
        // Walk down so the lowest index is the last one kept
        for (int k = `TCDM_GRP_SIZE-1; k >= 0; k--) begin
            if (lane_req_i[k]) lead = LIDX_W'(k);
        end
    end

    assign grp_req_o   = |lane_req_i;
    assign grp_add_o   = lane_add_i[lead];   // Row and bank group from lead lane
    assign grp_wen_o   = lane_wen_i[lead];
    assign grp_wdata_o = lane_wdata_i;

    // Idle lanes get no byte enables, so they never write
    always_comb begin
        for (int k = 0; k < `TCDM_GRP_SIZE; k++) begin
            grp_be_o[k] = lane_req_i[k] ? lane_be_i[k] : '0;
        end
    end

    //////////////////////////////////////////////////
    // Grant and response fan-out
    //////////////////////////////////////////////////
    assign lane_gnt_o = lane_req_i & {`TCDM_GRP_SIZE{grp_gnt_i}};

    always_ff @(posedge clk) begin
        if (!rst_n) pend_q <= '0;
        else        pend_q <= lane_gnt_o;   // Mask of lanes in flight
    end

    assign lane_r_valid_o = pend_q & {`TCDM_GRP_SIZE{grp_r_valid_i}};
    assign lane_r_rdata_o = grp_rdata_i;    // Lane k owns word k

endmodule

/* design/tcdm_pkg.sv */
/*
  Word-level types of the TCDM subsystem
  Group index types assume at least two groups
*/
`include "tcdm_settings.svh"

package tcdm_pkg;

    // Lane byte address
    typedef logic [`TCDM_ADDR_W-1:0] addr_t;

    // One data word and its byte enables
    typedef logic [`TCDM_DATA_W-1:0] data_t;
    typedef logic [`TCDM_BE_W-1:0]   be_t;

    // Row inside one bank
    typedef logic [`TCDM_ROW_W-1:0]  row_t;

    // Bank group picked by an address
    typedef logic [$clog2(`TCDM_N_GRP)-1:0] gsel_t;

    // Master group, i.e. which packer
    typedef logic [$clog2(`TCDM_N_GRP)-1:0] gidx_t;

endpackage

/* design/tcdm_settings.svh */
/*
  Sizing of the TCDM subsystem, shared by RTL and testbench
  Row and group-select fields must not overlap inside the byte address
*/
`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

//////////////////////////////////////////////////
// Lanes and groups
//////////////////////////////////////////////////
`define TCDM_N_LANES   8    // Engine lanes, also total banks
`define TCDM_GRP_SIZE  4    // Lanes per master group, banks per bank group
`define TCDM_N_GRP     2    // Master groups == bank groups

//////////////////////////////////////////////////
// Word and address layout
//////////////////////////////////////////////////
`define TCDM_DATA_W    32
`define TCDM_BE_W      (`TCDM_DATA_W/8)
`define TCDM_ADDR_W    32
`define TCDM_ROW_LSB   2    // Word address, byte offset dropped
`define TCDM_ROW_W     6    // 64 words per bank
`define TCDM_GSEL_LSB  8    // Bank-group select sits right above the row

`endif

/* design/tcdm_subsystem_top.sv */
/*
  TCDM subsystem top, eight lanes onto eight banks
  Lanes 0-3 form master group 0, lanes 4-7 master group 1
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_subsystem_top import tcdm_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic  [`TCDM_N_LANES-1:0]    req_i,
    input  addr_t [`TCDM_N_LANES-1:0]    add_i,
    input  logic  [`TCDM_N_LANES-1:0]    wen_i,       // 1 = load
    input  data_t [`TCDM_N_LANES-1:0]    wdata_i,
    input  be_t   [`TCDM_N_LANES-1:0]    be_i,
    output logic  [`TCDM_N_LANES-1:0]    gnt_o,
    output logic  [`TCDM_N_LANES-1:0]    r_valid_o,
    output data_t [`TCDM_N_LANES-1:0]    r_rdata_o
);

    // Packer to crossbar
    logic  [`TCDM_N_GRP-1:0]                     grp_req, grp_wen, grp_gnt, grp_r_valid;
    addr_t [`TCDM_N_GRP-1:0]                     grp_add;
    data_t [`TCDM_N_GRP-1:0][`TCDM_GRP_SIZE-1:0] grp_wdata, grp_rdata;
    be_t   [`TCDM_N_GRP-1:0][`TCDM_GRP_SIZE-1:0] grp_be;

    // Crossbar to banks
    logic  [`TCDM_N_LANES-1:0] bank_req, bank_wen;
    row_t  [`TCDM_N_LANES-1:0] bank_row;
    data_t [`TCDM_N_LANES-1:0] bank_wdata, bank_rdata;
    be_t   [`TCDM_N_LANES-1:0] bank_be;

    //////////////////////////////////////////////////
    // Lane packers
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `TCDM_N_GRP; g++) begin : g_packer
        localparam int LO = g*`TCDM_GRP_SIZE;   // First lane of the group

        tcdm_lane_packer i_packer (
            .clk            ( clk                                  ),
            .rst_n          ( rst_n                                ),
            .lane_req_i     ( req_i     [LO +: `TCDM_GRP_SIZE]     ),
            .lane_add_i     ( add_i     [LO +: `TCDM_GRP_SIZE]     ),
            .lane_wen_i     ( wen_i     [LO +: `TCDM_GRP_SIZE]     ),
            .lane_wdata_i   ( wdata_i   [LO +: `TCDM_GRP_SIZE]     ),
            .lane_be_i      ( be_i      [LO +: `TCDM_GRP_SIZE]     ),
            .lane_gnt_o     ( gnt_o     [LO +: `TCDM_GRP_SIZE]     ),
            .lane_r_valid_o ( r_valid_o [LO +: `TCDM_GRP_SIZE]     ),
            .lane_r_rdata_o ( r_rdata_o [LO +: `TCDM_GRP_SIZE]     ),
            .grp_req_o      ( grp_req[g]     ),
            .grp_add_o      ( grp_add[g]     ),
            .grp_wen_o      ( grp_wen[g]     ),
            .grp_wdata_o    ( grp_wdata[g]   ),
            .grp_be_o       ( grp_be[g]      ),
            .grp_gnt_i      ( grp_gnt[g]     ),
            .grp_r_valid_i  ( grp_r_valid[g] ),
            .grp_rdata_i    ( grp_rdata[g]   )
        );
    end

    //////////////////////////////////////////////////
    // Crossbar and banks
    //////////////////////////////////////////////////
    hwce_tcdm_xbar i_xbar (
        .clk           ( clk         ),
        .rst_n         ( rst_n       ),
        .grp_req_i     ( grp_req     ),
        .grp_add_i     ( grp_add     ),
        .grp_wen_i     ( grp_wen     ),
        .grp_wdata_i   ( grp_wdata   ),
        .grp_be_i      ( grp_be      ),
        .grp_gnt_o     ( grp_gnt     ),
        .grp_r_valid_o ( grp_r_valid ),
        .grp_rdata_o   ( grp_rdata   ),
        .bank_req_o    ( bank_req    ),
        .bank_row_o    ( bank_row    ),
        .bank_wen_o    ( bank_wen    ),
        .bank_wdata_o  ( bank_wdata  ),
        .bank_be_o     ( bank_be     ),
        .bank_rdata_i  ( bank_rdata  )
    );

    tcdm_bank_array i_banks (
        .clk          ( clk        ),
        .bank_req_i   ( bank_req   ),
        .bank_row_i   ( bank_row   ),
        .bank_wen_i   ( bank_wen   ),
        .bank_wdata_i ( bank_wdata ),
        .bank_be_i    ( bank_be    ),
        .bank_rdata_o ( bank_rdata )
    );

endmodule

/* tb/tcdm_checker.sv */
/*
  Scoreboard for the TCDM subsystem with a shadow copy of all banks
  Requesting lanes of a group must share row, bank group and access type
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_checker import tcdm_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  string                        test_name_i,
    input  logic  [`TCDM_N_LANES-1:0]    req_i,
    input  addr_t [`TCDM_N_LANES-1:0]    add_i,
    input  logic  [`TCDM_N_LANES-1:0]    wen_i,
    input  data_t [`TCDM_N_LANES-1:0]    wdata_i,
    input  be_t   [`TCDM_N_LANES-1:0]    be_i,
    input  logic  [`TCDM_N_LANES-1:0]    gnt_i,
    input  logic  [`TCDM_N_LANES-1:0]    r_valid_i,
    input  data_t [`TCDM_N_LANES-1:0]    r_rdata_i,
    output int                           checks_o,
    output int                           data_errs_o,
    output int                           proto_errs_o
);

    localparam int GS = `TCDM_GRP_SIZE;

    data_t                     shadow [`TCDM_N_LANES][1 << `TCDM_ROW_W];  // Bank, row
    logic  [`TCDM_N_LANES-1:0] pend;        // Lanes granted last edge
    logic  [`TCDM_N_LANES-1:0] pend_load;   // Of those, the loads
    data_t [`TCDM_N_LANES-1:0] exp_data;    // Word seen at grant

    // Reference merge, enabled bytes from wdata, rest from the old word
    function automatic data_t merge_word(input data_t old, input data_t wdata, input be_t be);
        data_t w;
        w = old;
        for (int b = 0; b < `TCDM_BE_W; b++) begin
            if (be[b]) w[8*b +: 8] = wdata[8*b +: 8];
        end
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Compare on every rising edge
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        logic  [`TCDM_N_GRP-1:0]   grp_req;
        logic  [`TCDM_N_GRP-1:0]   grp_gnt;
        gsel_t [`TCDM_N_GRP-1:0]   tgt;       // Bank group of each master group
        row_t  [`TCDM_N_GRP-1:0]   row;
        logic  [`TCDM_N_LANES-1:0] exp_gnt;
        int                        lead;
        int                        bank;
        int                        g;
        if (!rst_n) begin
            pend         = '0;
            pend_load    = '0;
            checks_o     = 0;
            data_errs_o  = 0;
            proto_errs_o = 0;
        end else begin
            // Responses to last edge's grants
            for (int l = 0; l < `TCDM_N_LANES; l++) begin
                if (r_valid_i[l] !== pend[l]) begin
                    proto_errs_o++;
                    $display("Lane %0d in %s: r_valid was %b where %b was expected",
                             l, test_name_i, r_valid_i[l], pend[l]);
                end else if (pend[l] && pend_load[l]) begin
                    checks_o++;
                    if (r_rdata_i[l] !== exp_data[l]) begin
                        data_errs_o++;
                        $display("Mismatch in %s lane %0d: expected %h, actual %h",
                                 test_name_i, l, exp_data[l], r_rdata_i[l]);
                    end
                end
            end
            // Expected grants, lower master group wins
            for (int gg = 0; gg < `TCDM_N_GRP; gg++) begin
                lead = 0;
                for (int k = GS-1; k >= 0; k--) begin
                    if (req_i[gg*GS+k]) lead = k;
                end
                grp_req[gg] = |req_i[gg*GS +: GS];
                tgt[gg]     = add_i[gg*GS+lead][`TCDM_GSEL_LSB +: $bits(gsel_t)];
                row[gg]     = add_i[gg*GS+lead][`TCDM_ROW_LSB +: `TCDM_ROW_W];
                grp_gnt[gg] = grp_req[gg];
                for (int h = 0; h < gg; h++) begin
                    if (grp_req[h] && tgt[h] == tgt[gg]) grp_gnt[gg] = 1'b0;
                end
            end
            // Record loads, then apply stores to the shadow
            for (int l = 0; l < `TCDM_N_LANES; l++) begin
                g          = l / GS;
                exp_gnt[l] = req_i[l] && grp_gnt[g];
                if (exp_gnt[l]) begin
                    bank = int'(tgt[g])*GS + l%GS;   // Lane k lands on bank k
                    if (wen_i[l]) begin
                        exp_data[l] = shadow[bank][row[g]];
                    end else begin
                        shadow[bank][row[g]] = merge_word(shadow[bank][row[g]],
                                                          wdata_i[l], be_i[l]);
                    end
                end
            end
            if (gnt_i !== exp_gnt) begin
                proto_errs_o++;
                $display("Grant pattern %b in %s differs from the priority rule result %b",
                         gnt_i, test_name_i, exp_gnt);
            end
            pend      = exp_gnt;
            pend_load = wen_i & exp_gnt;
        end
    end

endmodule

/* tb/tcdm_properties.sv */
/*
  Handshake assertions for the TCDM subsystem, bound into the top level
  fail_cnt holds the number of failed assertions for the closing report
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_properties import tcdm_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic  [`TCDM_N_LANES-1:0]    req_i,
    input  addr_t [`TCDM_N_LANES-1:0]    add_i,
    input  logic  [`TCDM_N_LANES-1:0]    wen_i,
    input  data_t [`TCDM_N_LANES-1:0]    wdata_i,
    input  be_t   [`TCDM_N_LANES-1:0]    be_i,
    input  logic  [`TCDM_N_LANES-1:0]    gnt_i,
    input  logic  [`TCDM_N_LANES-1:0]    r_valid_i
);

    int fail_cnt = 0;   // Failed assertions so far

    for (genvar l = 0; l < `TCDM_N_LANES; l++) begin : g_lane

        // Grant only answers a live request
        a_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
            gnt_i[l] |-> req_i[l])
        else begin
            fail_cnt++;
            $error("Lane %0d granted without a request", l);
        end

        // Response lands exactly one cycle later
        a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
            gnt_i[l] |=> r_valid_i[l])
        else begin
            fail_cnt++;
            $error("Lane %0d got no r_valid one cycle after its grant", l);
        end

        a_rvalid_needs_gnt: assert property (@(posedge clk) disable iff (!rst_n)
            r_valid_i[l] |-> $past(gnt_i[l]))
        else begin
            fail_cnt++;
            $error("Lane %0d raised r_valid without a grant in the cycle before", l);
        end

        // Waiting lane keeps its fields frozen
        a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
            req_i[l] && !gnt_i[l] |=> req_i[l] && $stable(add_i[l]) &&
            $stable(wen_i[l]) && $stable(wdata_i[l]) && $stable(be_i[l]))
        else begin
            fail_cnt++;
            $error("Lane %0d changed or dropped its request before the grant", l);
        end
    end

endmodule

bind tcdm_subsystem_top tcdm_properties i_props (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .req_i     ( req_i     ),
    .add_i     ( add_i     ),
    .wen_i     ( wen_i     ),
    .wdata_i   ( wdata_i   ),
    .be_i      ( be_i      ),
    .gnt_i     ( gnt_o     ),
    .r_valid_i ( r_valid_o )
);

/* tb/tcdm_subsystem_tb.sv */
/*
  Testbench for the TCDM subsystem, LFSR stimulus on the falling edge
  Every bank word is written once before any load reads it
*/
`timescale 1ns/10ps
`include "tcdm_settings.svh"

module tcdm_subsystem_tb import tcdm_pkg::*; ();

    localparam int GS         = `TCDM_GRP_SIZE;
    localparam int RST_CYCLES = 10;
    localparam int N_ROWS     = 1 << `TCDM_ROW_W;
    localparam int N_SINGLE   = 4;
    localparam int N_PARTIAL  = 8;
    localparam int N_DUAL     = 8;
    localparam int N_CONFLICT = 4;
    // Group accesses over the whole run
    localparam int N_ACC       = 2*N_ROWS + 2*N_SINGLE + 2*N_PARTIAL + 2*`TCDM_N_GRP
                               + 4*N_DUAL + 2*N_CONFLICT;
    localparam int CYCLE_LIMIT = 2*N_ACC + RST_CYCLES;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic  [`TCDM_N_LANES-1:0] req, wen, gnt, r_valid;
    addr_t [`TCDM_N_LANES-1:0] add;
    data_t [`TCDM_N_LANES-1:0] wdata, r_rdata;
    be_t   [`TCDM_N_LANES-1:0] be;
    string                     test_name = "reset";
    int                        checks, data_errs, proto_errs;
    int                        cycle = 0;
    logic  [15:0]              lfsr_q = 16'd78;
    data_t [GS-1:0]            wd;
    be_t   [GS-1:0]            wb;

    always #10 clk = ~clk;   // 20 ns period

    tcdm_subsystem_top i_dut (
        .clk (clk), .rst_n (rst_n), .req_i (req), .add_i (add), .wen_i (wen),
        .wdata_i (wdata), .be_i (be), .gnt_o (gnt), .r_valid_o (r_valid),
        .r_rdata_o (r_rdata)
    );

    tcdm_checker i_checker (
        .clk (clk), .rst_n (rst_n), .test_name_i (test_name), .req_i (req),
        .add_i (add), .wen_i (wen), .wdata_i (wdata), .be_i (be), .gnt_i (gnt),
        .r_valid_i (r_valid), .r_rdata_i (r_rdata), .checks_o (checks),
        .data_errs_o (data_errs), .proto_errs_o (proto_errs)
    );

    //////////////////////////////////////////////////
    // Random source and group drivers
    //////////////////////////////////////////////////
    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};   // One step per bit
        return v;
    endfunction

    task automatic random_words(output data_t [GS-1:0] w);
        for (int k = 0; k < GS; k++) w[k] = take_bits(`TCDM_DATA_W);
    endtask

    // All lanes of group g share one address, lane k hits bank k
    task automatic set_group(input int g, input logic [GS-1:0] mask, input logic load,
                             input gsel_t gs, input row_t row,
                             input data_t [GS-1:0] w, input be_t [GS-1:0] b);
        addr_t a;
        a = '0;
        a[`TCDM_GSEL_LSB +: $bits(gsel_t)] = gs;
        a[`TCDM_ROW_LSB +: `TCDM_ROW_W]    = row;
        for (int k = 0; k < GS; k++) begin
            req[g*GS+k]   = mask[k];
            add[g*GS+k]   = mask[k] ? a : '0;
            wen[g*GS+k]   = load;
            wdata[g*GS+k] = w[k];
            be[g*GS+k]    = b[k];
        end
    endtask

    // Hold each requesting group until granted, drop it on the next falling edge
    task automatic run_groups();
        logic [`TCDM_N_GRP-1:0] open;
        for (int g = 0; g < `TCDM_N_GRP; g++) open[g] = |req[g*GS +: GS];
        while (open != '0) begin
            @(posedge clk);
            for (int g = 0; g < `TCDM_N_GRP; g++) begin
                if (|gnt[g*GS +: GS]) open[g] = 1'b0;
            end
            @(negedge clk);
            for (int g = 0; g < `TCDM_N_GRP; g++) begin
                if (!open[g]) req[g*GS +: GS] = '0;
            end
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout, run still busy after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int             g;
        int             k;
        int             errs;
        gsel_t          gs;
        row_t           row;
        row_t           row1;
        logic [GS-1:0]  mask;
        rst_n = 1'b0;
        req   = '0;
        add   = '0;
        wen   = '0;
        wdata = '0;
        be    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "idle";   // Nothing requested, nothing granted
        repeat (5) @(negedge clk);

        test_name = "init";   // Both groups in parallel, one bank group each
        for (int r = 0; r < N_ROWS; r++) begin
            random_words(wd);
            set_group(0, '1, 1'b0, gsel_t'(0), row_t'(r), wd, '1);
            random_words(wd);
            set_group(1, '1, 1'b0, gsel_t'(1), row_t'(r), wd, '1);
            run_groups();
        end

        test_name = "single_store_load";
        for (int i = 0; i < N_SINGLE; i++) begin
            g    = int'(take_bits(1));
            k    = int'(take_bits(2));
            gs   = gsel_t'(take_bits(1));
            row  = row_t'(take_bits(`TCDM_ROW_W));
            mask = GS'(1 << k);
            random_words(wd);
            set_group(g, mask, 1'b0, gs, row, wd, '1);
            run_groups();
            set_group(g, mask, 1'b1, gs, row, wd, '1);
            run_groups();
        end

        test_name = "partial_be";
        for (int i = 0; i < N_PARTIAL; i++) begin
            g    = int'(take_bits(1));
            gs   = gsel_t'(take_bits(1));
            row  = row_t'(take_bits(`TCDM_ROW_W));
            mask = GS'(take_bits(GS));
            if (mask == '0) mask = GS'(1);
            random_words(wd);
            for (int j = 0; j < GS; j++) wb[j] = be_t'(take_bits(`TCDM_BE_W));
            set_group(g, mask, 1'b0, gs, row, wd, wb);
            run_groups();
            set_group(g, '1, 1'b1, gs, row, wd, '1);   // Read back all four banks
            run_groups();
        end

        test_name = "four_lane_group";
        for (int i = 0; i < `TCDM_N_GRP; i++) begin
            gs  = gsel_t'(take_bits(1));
            row = row_t'(take_bits(`TCDM_ROW_W));
            random_words(wd);
            set_group(i, '1, 1'b0, gs, row, wd, '1);
            run_groups();
            set_group(i, '1, 1'b1, gs, row, wd, '1);
            run_groups();
        end

        test_name = "dual_group";   // Disjoint bank groups, both granted at once
        for (int i = 0; i < N_DUAL; i++) begin
            gs   = gsel_t'(take_bits(1));
            row  = row_t'(take_bits(`TCDM_ROW_W));
            row1 = row_t'(take_bits(`TCDM_ROW_W));
            random_words(wd);
            set_group(0, '1, 1'b0, gs, row, wd, '1);
            random_words(wd);
            set_group(1, '1, 1'b0, ~gs, row1, wd, '1);
            run_groups();
            set_group(0, '1, 1'b1, gs, row, wd, '1);
            set_group(1, '1, 1'b1, ~gs, row1, wd, '1);
            run_groups();
        end

        test_name = "conflict";   // Group 1 waits, then reads group 0's store
        for (int i = 0; i < N_CONFLICT; i++) begin
            gs  = gsel_t'(take_bits(1));
            row = row_t'(take_bits(`TCDM_ROW_W));
            random_words(wd);
            set_group(0, '1, 1'b0, gs, row, wd, '1);
            set_group(1, '1, 1'b1, gs, row, wd, '1);
            run_groups();
        end

        test_name = "drain";
        repeat (3) @(negedge clk);
        errs = data_errs + proto_errs + i_dut.i_props.fail_cnt;
        if (checks == 0) begin
            $display("No load data was compared during the run");
            errs++;
        end
        $display("Loads compared %0d, data errors %0d, protocol errors %0d, assertion errors %0d",
                 checks, data_errs, proto_errs, i_dut.i_props.fail_cnt);
        if (errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tcdm_subsystem_top.f */
+incdir+design
design/tcdm_pkg.sv
design/tcdm_lane_packer.sv
design/tcdm_bank_sel.sv
design/hwce_tcdm_xbar.sv
design/tcdm_bank_array.sv
design/tcdm_subsystem_top.sv
tb/tcdm_properties.sv
tb/tcdm_checker.sv
tb/tcdm_subsystem_tb.sv
